// File: run_sim.sh
#!/bin/sh
# Builds and runs the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module tb_rv_exec_top \
        -Mdir obj_dir -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi
exit 0

// File: sim/tb_rv_exec_vectors.svh
`ifndef TB_RV_EXEC_VECTORS_SVH
`define TB_RV_EXEC_VECTORS_SVH

    // Directed vectors
    // --------------------
    // Columns: instruction, pc, rs1, rs2, csr, rslt, {rd_we, br_taken, illegal}, br_target
    task automatic build_vectors();
        // Arithmetic, logic and shifts
        add_vec(r_type(f7_base, 3'b000), 0, 'h5, 'h7, 0, 'hc, 3'b100, 0);
        add_vec(r_type(f7_alt, 3'b000), 0, 'h3, 'h5, 0, 'hfffffffe, 3'b100, 0);
        add_vec(i_type(12'hfff, 3'b000, op_imm), 0, 'h10, 0, 0, 'hf, 3'b100, 0);
        add_vec(i_type(12'h005, 3'b010, op_imm), 0, 'hffffffff, 0, 0, 'h1, 3'b100, 0);
        add_vec(i_type(12'h0ff, 3'b100, op_imm), 0, 'h0f0f, 0, 0, 'hff0, 3'b100, 0);
        add_vec(i_type(12'h800, 3'b110, op_imm), 0, 'h1, 0, 0, 'hfffff801, 3'b100, 0);
        add_vec(i_type(12'h01f, 3'b001, op_imm), 0, 'h3, 0, 0, 'h80000000, 3'b100, 0);
        add_vec(i_type(12'h41f, 3'b101, op_imm), 0, 'h80000000, 0, 0, 'hffffffff, 3'b100, 0);
        add_vec(r_type(f7_base, 3'b001), 0, 'h1, 'h25, 0, 'h20, 3'b100, 0); // Shamt from low bits
        add_vec(r_type(f7_base, 3'b101), 0, 'hffffffff, 'h1f, 0, 'h1, 3'b100, 0);
        add_vec(r_type(f7_alt, 3'b101), 0, 'hf0000000, 'h4, 0, 'hff000000, 3'b100, 0);
        add_vec(r_type(f7_base, 3'b010), 0, 'h80000000, 'h1, 0, 'h1, 3'b100, 0);
        add_vec(r_type(f7_base, 3'b011), 0, 'h80000000, 'h1, 0, 0, 3'b100, 0);
        add_vec(r_type(f7_base, 3'b100), 0, 'hff00ff00, 'h0ff00ff0, 0, 'hf0f0f0f0, 3'b100, 0);
        add_vec(r_type(f7_base, 3'b111), 0, 'hff00ff00, 'h0ff00ff0, 0, 'h0f000f00, 3'b100, 0);
        // M extension
        add_vec(r_type(f7_muldiv, 3'b000), 0, 'hfffffffe, 'h3, 0, 'hfffffffa, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b001), 0, 'h80000000, 'h80000000, 0, 'h40000000, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b010), 0, 'hffffffff, 'hffffffff, 0, 'hffffffff, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b011), 0, 'hffffffff, 'hffffffff, 0, 'hfffffffe, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b100), 0, 'hfffffff9, 'h2, 0, 'hfffffffd, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b100), 0, 'h5, 0, 0, 'hffffffff, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b100), 0, 'h80000000, 'hffffffff, 0, 'h80000000, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b101), 0, 'hfffffff9, 'h2, 0, 'h7ffffffc, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b110), 0, 'hfffffff9, 'h2, 0, 'hffffffff, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b110), 0, 'h80000000, 'hffffffff, 0, 0, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b110), 0, 'hfffffff9, 0, 0, 'hfffffff9, 3'b100, 0);
        add_vec(r_type(f7_muldiv, 3'b111), 0, 'hfffffff9, 'h2, 0, 'h1, 3'b100, 0);
        // Branches and jumps, rslt of a branch is not defined
        add_vec(b_type(13'h010, 3'b000), 'h100, 'h5, 'h5, 0, 0, 3'b010, 'h110);
        add_vec(b_type(13'h010, 3'b001), 'h100, 'h5, 'h5, 0, 0, 3'b000, 'h110);
        add_vec(b_type(13'h1ff8, 3'b100), 'h100, 'hffffffff, 'h1, 0, 0, 3'b010, 'hf8);
        add_vec(b_type(13'h010, 3'b101), 'h100, 'hffffffff, 'h1, 0, 0, 3'b000, 'h110);
        add_vec(b_type(13'h010, 3'b110), 'h100, 'h1, 'hffffffff, 0, 0, 3'b010, 'h110);
        add_vec(b_type(13'h010, 3'b111), 'h100, 'h1, 'hffffffff, 0, 0, 3'b000, 'h110);
        add_vec(j_type(21'h000800), 'h1000, 0, 0, 0, 'h1004, 3'b110, 'h1800);
        add_vec(j_type(21'h1ffff8), 'h1000, 0, 0, 0, 'h1004, 3'b110, 'hff8);
        add_vec(i_type(12'h007, 3'b000, op_jalr), 'h2000, 'h300, 0, 0, 'h2004, 3'b110, 'h306);
        // Upper immediates, addresses and CSR values
        add_vec(u_type(20'h12345, op_lui), 0, 0, 0, 0, 'h12345000, 3'b100, 0);
        add_vec(u_type(20'hfffff, op_auipc), 'h3000, 0, 0, 0, 'h2000, 3'b100, 0);
        add_vec(i_type(12'hffc, 3'b010, op_load), 0, 'h100, 0, 0, 'hfc, 3'b100, 0);
        add_vec(s_type(12'h7ff), 0, 'h100, 'hdead, 0, 'h8ff, 3'b000, 0);
        add_vec(i_type(12'h300, 3'b001, op_system), 0, 'haa, 0, 'h55, 'haa, 3'b100, 0);
        add_vec(i_type(12'h300, 3'b010, op_system), 0, 'h0f, 0, 'hf0, 'hff, 3'b100, 0);
        add_vec(i_type(12'h300, 3'b011, op_system), 0, 'h0f, 0, 'hff, 'hf0, 3'b100, 0);
        add_vec(i_type(12'h300, 3'b101, op_system), 0, 'h1234, 0, 'hff, 'h1, 3'b100, 0);
        add_vec(i_type(12'h300, 3'b110, op_system), 0, 'h1234, 0, 'hf0, 'hf1, 3'b100, 0);
        add_vec(i_type(12'h300, 3'b111, op_system), 0, 'h1234, 0, 'hff, 'hfe, 3'b100, 0);
        // Write to x0 and unknown encodings
        add_vec('h00208033, 0, 'h5, 'h7, 0, 'hc, 3'b000, 0);
        add_vec('hffffffff, 'h40, 'h5, 'h7, 'h9, 0, 3'b001, 0);
        add_vec(r_type(7'b0000010, 3'b000), 0, 'h5, 'h7, 0, 0, 3'b001, 0);
    endtask

`endif

// File: sim/tb_rv_exec_top.sv
module tb_rv_exec_top;
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;

    typedef struct packed {
        inst_word_t inst;
        word_t      pc;
        word_t      rs1;
        word_t      rs2;
        word_t      csr;
        word_t      rslt;
        logic       we;
        logic       taken;
        logic       ill;
        word_t      target;
    } vec_t;

    logic       clk;
    logic       rst_n;
    logic       ex_ready;
    inst_word_t inst_word;
    word_t      pc;
    word_t      rs1;
    word_t      rs2;
    word_t      csr;
    word_t      rslt;
    logic       result_valid;
    logic       rd_we;
    reg_idx_t   rd;
    logic       br_taken;
    word_t      br_target;
    logic       illegal;

    vec_t        vectors[$];
    word_t       exp_q[$];
    int          seed = 3;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;

    rv_exec_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_ready     (ex_ready),
        .inst_word    (inst_word),
        .pc           (pc),
        .rs1          (rs1),
        .rs2          (rs2),
        .csr          (csr),
        .rslt         (rslt),
        .result_valid (result_valid),
        .rd_we        (rd_we),
        .rd           (rd),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Testbench failed");
            $fatal(1, "timeout, the test did not end within %0d cycles", cycle_limit);
        end
    end

    // Encoders with rs1 = x1, rs2 = x2 and rd = x3
    // --------------------
    function automatic inst_word_t r_type(funct7_t f7, funct3_t f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op_reg};
    endfunction

    function automatic inst_word_t i_type(logic [11:0] imm, funct3_t f3, opcode_t op);
        return {imm, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic inst_word_t s_type(logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic inst_word_t b_type(logic [12:0] imm, funct3_t f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic inst_word_t u_type(logic [19:0] imm, opcode_t op);
        return {imm, 5'd3, op};
    endfunction

    function automatic inst_word_t j_type(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, op_jal};
    endfunction

    task automatic add_vec(input inst_word_t inst_v, input word_t pc_v, rs1_v, rs2_v, csr_v,
                           input word_t rslt_v, input logic [2:0] flags, input word_t tgt_v);
        vec_t v;
        v = '{inst_v, pc_v, rs1_v, rs2_v, csr_v, rslt_v, flags[2], flags[1], flags[0], tgt_v};
        vectors.push_back(v);
    endtask

    `include "tb_rv_exec_vectors.svh"

    // Compare tasks
    // --------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic apply_vec(input vec_t v);
        logic is_ctl;
        is_ctl = (v.inst[6:0] == op_branch) || (v.inst[6:0] == op_jal) ||
                 (v.inst[6:0] == op_jalr);
        @(posedge clk);
        inst_word <= v.inst;
        pc        <= v.pc;
        rs1       <= v.rs1;
        rs2       <= v.rs2;
        csr       <= v.csr;
        ex_ready  <= 1'b1;
        @(posedge clk);
        ex_ready <= 1'b0;
        @(negedge clk); // Cycle after the strobe
        check_bit("result_valid", result_valid, 1'b1);
        if (v.inst[6:0] != op_branch) begin
            check_word("rslt", rslt, v.rslt);
        end
        check_bit("rd_we", rd_we, v.we);
        if (v.we) begin
            check_reg("rd", rd, v.inst[11:7]);
        end
        check_bit("br_taken", br_taken, v.taken);
        if (is_ctl) begin
            check_word("br_target", br_target, v.target);
        end
        check_bit("illegal", illegal, v.ill);
        @(negedge clk);
        check_bit("result_valid", result_valid, 1'b0); // Single pulse
    endtask

    initial begin
        int unsigned sel;
        word_t       a;
        word_t       b;

        rst_n     = 1'b0;
        ex_ready  = 1'b1; // JAL strobe that reset has to override
        inst_word = j_type(21'h000800);
        pc        = 'h1000;
        rs1       = '0;
        rs2       = '0;
        csr       = '0;
        build_vectors();
        cycle_limit = 4 * (vectors.size() + 50) + 20;

        repeat (2) @(posedge clk);
        rst_n    <= 1'b1;
        ex_ready <= 1'b0;
        @(negedge clk);
        check_word("rslt", rslt, '0);
        check_bit("result_valid", result_valid, 1'b0);
        check_bit("rd_we", rd_we, 1'b0);
        check_bit("br_taken", br_taken, 1'b0);
        check_bit("illegal", illegal, 1'b0);

        for (int i = 0; i < vectors.size(); i++) begin
            apply_vec(vectors[i]);
        end

        // Back-to-back ADD/SUB/XOR with one strobe per cycle
        // --------------------
        for (int i = 0; i <= 50; i++) begin
            @(posedge clk);
            if (i < 50) begin
                sel = {$random(seed)} % 3;
                a   = $random(seed);
                b   = $random(seed);
                pc  <= '0;
                csr <= '0;
                rs1 <= a;
                rs2 <= b;
                case (sel)
                    0: begin
                        inst_word <= r_type(f7_base, 3'b000);
                        exp_q.push_back(a + b);
                    end
                    1: begin
                        inst_word <= r_type(f7_alt, 3'b000);
                        exp_q.push_back(a - b);
                    end
                    default: begin
                        inst_word <= r_type(f7_base, 3'b100);
                        exp_q.push_back(a ^ b);
                    end
                endcase
                ex_ready <= 1'b1;
            end else begin
                ex_ready <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin // Result of the previous strobe
                check_bit("result_valid", result_valid, 1'b1);
                check_word("rslt", rslt, exp_q.pop_front());
                check_bit("rd_we", rd_we, 1'b1);
                check_reg("rd", rd, 5'd3);
                check_bit("br_taken", br_taken, 1'b0);
                check_bit("illegal", illegal, 1'b0);
            end
        end
        @(negedge clk);
        check_bit("result_valid", result_valid, 1'b0);

        $display("Testbench passed");
        $finish;
    end

endmodule : tb_rv_exec_top

// File: source/rv_alu.sv
module rv_alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ex_ready,
    input  rv_exec_pkg::dec_op_t dec,
    input  rv_exec_pkg::word_t   rs1,
    input  rv_exec_pkg::word_t   rs2,
    input  rv_exec_pkg::word_t   pc,
    input  rv_exec_pkg::word_t   csr,
    output rv_exec_pkg::word_t   rslt,
    output logic                 cond_met
);
    import rv_exec_pkg::*;

    inst_t  op;
    word_t  a;
    word_t  b;
    shamt_t shamt;
    logic   is_branch;
    logic   eq;
    logic   lt;
    logic   ltu;
    word_t  add_sub;
    dword_t mul_ss;
    dword_t mul_su;
    dword_t mul_uu;
    word_t  div_s;
    word_t  rem_s;
    word_t  div_u;
    word_t  rem_u;
    word_t  result;

    assign op    = dec.inst;
    assign shamt = b[4:0]; // Register and immediate shifts alike

    // Operand select
    // --------------------
    always_comb begin
        if (op.AUIPC | op.JAL | op.JALR) begin
            a = pc;
        end else if (op.CSRRWI | op.CSRRSI | op.CSRRCI) begin
            a = word_t'(dec.zimm);
        end else begin
            a = rs1;
        end

        if (op.JAL | op.JALR) begin
            b = word_t'(4); // Link address
        end else if (op.LUI | op.AUIPC | op.LB | op.LH | op.LW | op.LBU | op.LHU | op.SB |
                     op.SH | op.SW | op.ADDI | op.SLTI | op.SLTIU | op.XORI | op.ORI |
                     op.ANDI | op.SLLI | op.SRLI | op.SRAI) begin
            b = dec.imm;
        end else if (op.CSRRW | op.CSRRS | op.CSRRC | op.CSRRWI | op.CSRRSI | op.CSRRCI) begin
            b = csr;
        end else begin
            b = rs2;
        end
    end

    // Compares, shared by SLT* and branches
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    assign is_branch = op.BEQ | op.BNE | op.BLT | op.BGE | op.BLTU | op.BGEU;
    assign cond_met  = (op.BEQ & eq) | (op.BNE & ~eq) | (op.BLT & lt) | (op.BGE & ~lt) |
                       (op.BLTU & ltu) | (op.BGEU & ~ltu);

    assign add_sub = op.SUB ? a - b : a + b;

    // Low 64 bits of the extended products
    assign mul_ss = {{xlen{a[xlen-1]}}, a} * {{xlen{b[xlen-1]}}, b};
    assign mul_su = {{xlen{a[xlen-1]}}, a} * {{xlen{1'b0}}, b};
    assign mul_uu = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};

    // Division with the RISC-V corner cases
    // --------------------
    always_comb begin
        if (b == '0) begin
            div_u = '1;
            rem_u = a;
            div_s = '1;
            rem_s = a;
        end else begin
            div_u = a / b;
            rem_u = a % b;
            if (a == {1'b1, {(xlen-1){1'b0}}} && b == '1) begin
                div_s = a; // Overflow keeps the most negative value
                rem_s = '0;
            end else begin
                div_s = word_t'($signed(a) / $signed(b));
                rem_s = word_t'($signed(a) % $signed(b));
            end
        end
    end

    // Result select
    // --------------------
    always_comb begin
        if (is_branch) begin
            result = word_t'(cond_met);
        end else if (op.SLT | op.SLTI) begin
            result = word_t'(lt);
        end else if (op.SLTU | op.SLTIU) begin
            result = word_t'(ltu);
        end else if (op.LUI) begin
            result = b;
        end else if (op.AUIPC | op.JAL | op.JALR | op.LB | op.LH | op.LW | op.LBU | op.LHU |
                     op.SB | op.SH | op.SW | op.ADDI | op.ADD | op.SUB) begin
            result = add_sub;
        end else if (op.SLL | op.SLLI) begin
            result = a << shamt;
        end else if (op.SRL | op.SRLI) begin
            result = a >> shamt;
        end else if (op.SRA | op.SRAI) begin
            result = word_t'($signed(a) >>> shamt);
        end else if (op.XOR | op.XORI) begin
            result = a ^ b;
        end else if (op.OR | op.ORI | op.CSRRS | op.CSRRSI) begin
            result = a | b;
        end else if (op.AND | op.ANDI) begin
            result = a & b;
        end else if (op.CSRRW | op.CSRRWI) begin
            result = a;
        end else if (op.CSRRC | op.CSRRCI) begin
            result = ~a & b;
        end else if (op.MUL) begin
            result = mul_uu[xlen-1:0];
        end else if (op.MULH) begin
            result = mul_ss[2*xlen-1:xlen];
        end else if (op.MULHSU) begin
            result = mul_su[2*xlen-1:xlen];
        end else if (op.MULHU) begin
            result = mul_uu[2*xlen-1:xlen];
        end else if (op.DIV) begin
            result = div_s;
        end else if (op.DIVU) begin
            result = div_u;
        end else if (op.REM) begin
            result = rem_s;
        end else if (op.REMU) begin
            result = rem_u;
        end else begin
            result = '0; // Illegal encoding
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rslt <= '0;
        end else if (ex_ready) begin
            rslt <= result;
        end
    end

    // A strobed instruction always yields a defined result
    a_rslt_known: assert property (
        @(posedge clk) disable iff (!rst_n) ex_ready |=> !$isunknown(rslt)
    );

endmodule : rv_alu

// File: source/rv_decoder.sv
module rv_decoder (
    input  rv_isa_pkg::inst_word_t inst_word,
    output rv_exec_pkg::dec_op_t   dec
);
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    inst_t   inst;
    word_t   imm;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;

    assign opcode = inst_word[6:0];
    assign funct3 = inst_word[14:12];
    assign funct7 = inst_word[31:25];

    // Immediate formats
    // --------------------
    assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
    assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
    assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7], inst_word[30:25],
                    inst_word[11:8], 1'b0};
    assign imm_u = {inst_word[31:12], 12'b0};
    assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12], inst_word[20],
                    inst_word[30:21], 1'b0};

    always_comb begin
        case (opcode)
            op_lui, op_auipc:         imm = imm_u;
            op_jal:                   imm = imm_j;
            op_branch:                imm = imm_b;
            op_store:                 imm = imm_s;
            op_jalr, op_load, op_imm: imm = imm_i;
            default:                  imm = '0;
        endcase
    end

    // Instruction flags
    // --------------------
    always_comb begin
        inst = '0;
        case (opcode)
            op_lui:    inst.LUI   = 1'b1;
            op_auipc:  inst.AUIPC = 1'b1;
            op_jal:    inst.JAL   = 1'b1;
            op_jalr:   inst.JALR  = (funct3 == 3'b000);
            op_branch: begin
                inst.BEQ  = (funct3 == 3'b000);
                inst.BNE  = (funct3 == 3'b001);
                inst.BLT  = (funct3 == 3'b100);
                inst.BGE  = (funct3 == 3'b101);
                inst.BLTU = (funct3 == 3'b110);
                inst.BGEU = (funct3 == 3'b111);
            end
            op_load: begin
                inst.LB  = (funct3 == 3'b000);
                inst.LH  = (funct3 == 3'b001);
                inst.LW  = (funct3 == 3'b010);
                inst.LBU = (funct3 == 3'b100);
                inst.LHU = (funct3 == 3'b101);
            end
            op_store: begin
                inst.SB = (funct3 == 3'b000);
                inst.SH = (funct3 == 3'b001);
                inst.SW = (funct3 == 3'b010);
            end
            op_imm: begin
                inst.ADDI  = (funct3 == 3'b000);
                inst.SLTI  = (funct3 == 3'b010);
                inst.SLTIU = (funct3 == 3'b011);
                inst.XORI  = (funct3 == 3'b100);
                inst.ORI   = (funct3 == 3'b110);
                inst.ANDI  = (funct3 == 3'b111);
                inst.SLLI  = (funct3 == 3'b001) && (funct7 == f7_base);
                inst.SRLI  = (funct3 == 3'b101) && (funct7 == f7_base);
                inst.SRAI  = (funct3 == 3'b101) && (funct7 == f7_alt);
            end
            op_reg: begin
                inst.ADD    = (funct3 == 3'b000) && (funct7 == f7_base);
                inst.SUB    = (funct3 == 3'b000) && (funct7 == f7_alt);
                inst.SLL    = (funct3 == 3'b001) && (funct7 == f7_base);
                inst.SLT    = (funct3 == 3'b010) && (funct7 == f7_base);
                inst.SLTU   = (funct3 == 3'b011) && (funct7 == f7_base);
                inst.XOR    = (funct3 == 3'b100) && (funct7 == f7_base);
                inst.SRL    = (funct3 == 3'b101) && (funct7 == f7_base);
                inst.SRA    = (funct3 == 3'b101) && (funct7 == f7_alt);
                inst.OR     = (funct3 == 3'b110) && (funct7 == f7_base);
                inst.AND    = (funct3 == 3'b111) && (funct7 == f7_base);
                inst.MUL    = (funct3 == 3'b000) && (funct7 == f7_muldiv);
                inst.MULH   = (funct3 == 3'b001) && (funct7 == f7_muldiv);
                inst.MULHSU = (funct3 == 3'b010) && (funct7 == f7_muldiv);
                inst.MULHU  = (funct3 == 3'b011) && (funct7 == f7_muldiv);
                inst.DIV    = (funct3 == 3'b100) && (funct7 == f7_muldiv);
                inst.DIVU   = (funct3 == 3'b101) && (funct7 == f7_muldiv);
                inst.REM    = (funct3 == 3'b110) && (funct7 == f7_muldiv);
                inst.REMU   = (funct3 == 3'b111) && (funct7 == f7_muldiv);
            end
            op_system: begin
                inst.CSRRW  = (funct3 == 3'b001);
                inst.CSRRS  = (funct3 == 3'b010);
                inst.CSRRC  = (funct3 == 3'b011);
                inst.CSRRWI = (funct3 == 3'b101);
                inst.CSRRSI = (funct3 == 3'b110);
                inst.CSRRCI = (funct3 == 3'b111);
            end
            default: ; // Unknown opcode, no flag
        endcase
    end

    assign dec = '{
        inst:    inst,
        imm:     imm,
        zimm:    inst_word[19:15],
        rd:      inst_word[11:7],
        illegal: (inst == '0)
    };

    always_comb begin
        assert ($onehot0(dec.inst))
            else $error("decoder raised more than one instruction flag");
    end

endmodule : rv_decoder

// File: source/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0]   word_t;
    typedef logic [2*xlen-1:0] dword_t; // Full product
    typedef logic [4:0]        shamt_t;

    // One flag per supported instruction
    // --------------------
    typedef struct packed {
        logic LUI, AUIPC, JAL, JALR;
        logic BEQ, BNE, BLT, BGE, BLTU, BGEU;
        logic LB, LH, LW, LBU, LHU;
        logic SB, SH, SW;
        logic ADDI, SLTI, SLTIU, XORI, ORI, ANDI;
        logic SLLI, SRLI, SRAI;
        logic ADD, SUB, SLL, SLT, SLTU;
        logic XOR, SRL, SRA, OR, AND;
        logic MUL, MULH, MULHSU, MULHU;
        logic DIV, DIVU, REM, REMU;
        logic CSRRW, CSRRS, CSRRC;
        logic CSRRWI, CSRRSI, CSRRCI;
    } inst_t;

    // Decoder output shared by the stage modules
    typedef struct packed {
        inst_t                inst;
        word_t                imm;
        shamt_t               zimm;  // rs1 field of CSR immediate forms
        rv_isa_pkg::reg_idx_t rd;
        logic                 illegal;
    } dec_op_t;

endpackage : rv_exec_pkg

// File: source/rv_exec_top.sv
module rv_exec_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ex_ready,
    input  rv_isa_pkg::inst_word_t inst_word,
    input  rv_exec_pkg::word_t     pc,
    input  rv_exec_pkg::word_t     rs1,
    input  rv_exec_pkg::word_t     rs2,
    input  rv_exec_pkg::word_t     csr,
    output rv_exec_pkg::word_t     rslt,
    output logic                   result_valid,
    output logic                   rd_we,
    output rv_isa_pkg::reg_idx_t   rd,
    output logic                   br_taken,
    output rv_exec_pkg::word_t     br_target,
    output logic                   illegal
);
    import rv_exec_pkg::*;

    dec_op_t dec;
    logic    cond_met; // Branch compare from the ALU

    rv_decoder u_decoder (
        .inst_word (inst_word),
        .dec       (dec)
    );

    rv_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_ready (ex_ready),
        .dec      (dec),
        .rs1      (rs1),
        .rs2      (rs2),
        .pc       (pc),
        .csr      (csr),
        .rslt     (rslt),
        .cond_met (cond_met)
    );

    rv_result_stage u_result_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_ready     (ex_ready),
        .dec          (dec),
        .pc           (pc),
        .rs1          (rs1),
        .cond_met     (cond_met),
        .result_valid (result_valid),
        .rd_we        (rd_we),
        .br_taken     (br_taken),
        .illegal      (illegal),
        .rd           (rd),
        .br_target    (br_target)
    );

endmodule : rv_exec_top

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // Instruction word fields
    // --------------------
    typedef logic [31:0] inst_word_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes
    // --------------------
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_system = 7'b1110011;

    // funct7 codes
    localparam funct7_t f7_base   = 7'b0000000;
    localparam funct7_t f7_alt    = 7'b0100000; // SUB, SRA, SRAI
    localparam funct7_t f7_muldiv = 7'b0000001; // M extension

endpackage : rv_isa_pkg

// File: source/rv_result_stage.sv
module rv_result_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ex_ready,
    input  rv_exec_pkg::dec_op_t dec,
    input  rv_exec_pkg::word_t   pc,
    input  rv_exec_pkg::word_t   rs1,
    input  logic                 cond_met,
    output logic                 result_valid,
    output logic                 rd_we,
    output logic                 br_taken,
    output logic                 illegal,
    output rv_isa_pkg::reg_idx_t rd,
    output rv_exec_pkg::word_t   br_target
);
    import rv_exec_pkg::*;

    inst_t op;
    logic  is_branch;
    logic  is_store;
    logic  taken_c;
    logic  we_c;
    word_t target_c;

    assign op        = dec.inst;
    assign is_branch = op.BEQ | op.BNE | op.BLT | op.BGE | op.BLTU | op.BGEU;
    assign is_store  = op.SB | op.SH | op.SW;

    // JALR is register based with bit 0 cleared
    assign target_c = op.JALR ? ((rs1 + dec.imm) & ~word_t'(1)) : pc + dec.imm;
    assign taken_c  = op.JAL | op.JALR | (is_branch & cond_met);
    assign we_c     = !dec.illegal && !is_branch && !is_store && (dec.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            rd_we        <= 1'b0;
            br_taken     <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= ex_ready; // One pulse per strobe
            if (ex_ready) begin
                rd_we    <= we_c;
                br_taken <= taken_c;
                illegal  <= dec.illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ready) begin
            rd        <= dec.rd;
            br_target <= target_c;
        end
    end

    // Taken flag only for a legal jump or branch
    a_taken_is_legal: assert property (
        @(posedge clk) disable iff (!rst_n) br_taken |-> !illegal
    );

endmodule : rv_result_stage

// File: vlog.f
+incdir+sim
source/rv_isa_pkg.sv
source/rv_exec_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_result_stage.sv
source/rv_exec_top.sv
sim/tb_rv_exec_top.sv
